/* hdl/memreq_defs.svh */
`ifndef MEMREQ_DEFS_SVH
`define MEMREQ_DEFS_SVH

// Memory side widths
`define ADDR_WIDTH 28
`define ID_WIDTH 4
`define DATA_WIDTH 32
`define STROBES 4

// Read beats buffered ahead of the output stream
`define RD_FIFO_DEPTH 16

// AXI codes
`define BURST_INCR 2'b01
`define RESP_OKAY 2'b00

`endif

/* hdl/memreq_pkg.sv */
`include "memreq_defs.svh"

package memreq_pkg;

  // Command bytes from the host and status bytes back to it
  typedef enum logic [7:0] {
    STORE = 8'h01,
    WDONE = 8'h02,
    WFAIL = 8'h03,
    FETCH = 8'h80,
    RDATA = 8'h81,
    RFAIL = 8'h82
  } cmd_e;

  // Header bytes arrive as len, addr[7:0], addr[15:8], addr[23:16],
  // then {id, addr[27:24]}
  typedef union packed {
    logic [4:0][7:0] bytes;  // Byte 0 is the first one received
    struct packed {
      logic [`ID_WIDTH-1:0] id;
      logic [`ADDR_WIDTH-1:0] addr;
      logic [7:0] len;  // Beats minus one
    } f;
  } req_header_u;

endpackage

/* hdl/cmd_parser.sv */
`timescale 1ns/100ps

module cmd_parser (
  input  logic bus_clock,
  input  logic bus_reset,
  input  logic s_tvalid_i,
  output logic s_tready_o,
  input  logic s_tlast_i,
  input  logic [7:0] s_tdata_i,
  output memreq_pkg::req_header_u header_o,
  output logic is_read_o,
  output logic req_go_o,
  output logic byte_valid_o,
  output logic byte_last_o,
  output logic [7:0] byte_o,
  input  logic byte_ready_i,
  input  logic resp_done_i
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_HEAD = 2'd1;
  localparam logic [1:0] ST_WDATA = 2'd2;
  localparam logic [1:0] ST_WAIT = 2'd3;

  logic [1:0] state_q;
  logic [2:0] count_q;  // Header bytes taken so far
  logic s_fire;

  assign s_fire = s_tvalid_i && s_tready_o;

  always_comb begin
    case (state_q)
      ST_IDLE, ST_HEAD: s_tready_o = 1'b1;
      ST_WDATA: s_tready_o = byte_ready_i;  // Packer back-pressure
      default: s_tready_o = 1'b0;
    endcase
  end

  // Fires with the fifth header byte
  assign req_go_o = state_q == ST_HEAD && s_fire && count_q == 3'd4;

  assign byte_valid_o = state_q == ST_WDATA && s_tvalid_i;
  assign byte_last_o = s_tlast_i;
  assign byte_o = s_tdata_i;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= ST_IDLE;
      count_q <= 3'd0;
      is_read_o <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (s_fire) begin
            is_read_o <= s_tdata_i[7];
            count_q <= 3'd0;
            state_q <= ST_HEAD;
          end
        end
        ST_HEAD: begin
          if (s_fire) begin
            count_q <= count_q + 3'd1;
            if (count_q == 3'd4) begin
              state_q <= is_read_o ? ST_WAIT : ST_WDATA;
            end
          end
        end
        ST_WDATA: state_q <= s_fire && s_tlast_i ? ST_WAIT : state_q;
        default: state_q <= resp_done_i ? ST_IDLE : state_q;
      endcase
    end
  end

  // New bytes enter at the top, so the first ends up in byte 0
  always_ff @(posedge bus_clock) begin
    if (state_q == ST_HEAD && s_fire) begin
      header_o.bytes <= {s_tdata_i, header_o.bytes[4:1]};
    end
  end

endmodule

/* hdl/addr_issue.sv */
`timescale 1ns/100ps
`include "memreq_defs.svh"

module addr_issue (
  input  logic bus_clock,
  input  logic bus_reset,
  input  logic req_go_i,
  input  logic is_read_i,
  input  memreq_pkg::req_header_u header_i,
  output logic awvalid_o,
  input  logic awready_i,
  output logic [`ADDR_WIDTH-1:0] awaddr_o,
  output logic [`ID_WIDTH-1:0] awid_o,
  output logic [7:0] awlen_o,
  output logic [1:0] awburst_o,
  output logic arvalid_o,
  input  logic arready_i,
  output logic [`ADDR_WIDTH-1:0] araddr_o,
  output logic [`ID_WIDTH-1:0] arid_o,
  output logic [7:0] arlen_o,
  output logic [1:0] arburst_o
);

  logic pend_q, read_q;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      pend_q <= 1'b0;
      read_q <= 1'b0;
    end else if (req_go_i) begin
      pend_q <= 1'b1;
      read_q <= is_read_i;
    end else if (awvalid_o && awready_i || arvalid_o && arready_i) begin
      pend_q <= 1'b0;
    end
  end

  assign awvalid_o = pend_q && !read_q;
  assign arvalid_o = pend_q && read_q;

  // Header stays put until the response has gone out
  assign awaddr_o = header_i.f.addr;
  assign awid_o = header_i.f.id;
  assign awlen_o = header_i.f.len;
  assign awburst_o = `BURST_INCR;
  assign araddr_o = header_i.f.addr;
  assign arid_o = header_i.f.id;
  assign arlen_o = header_i.f.len;
  assign arburst_o = `BURST_INCR;

endmodule

/* hdl/wr_packer.sv */
`timescale 1ns/100ps
`include "memreq_defs.svh"

module wr_packer (
  input  logic bus_clock,
  input  logic bus_reset,
  input  logic byte_valid_i,
  input  logic byte_last_i,
  input  logic [7:0] byte_i,
  output logic byte_ready_o,
  output logic wvalid_o,
  input  logic wready_i,
  output logic wlast_o,
  output logic [`STROBES-1:0] wstrb_o,
  output logic [`DATA_WIDTH-1:0] wdata_o
);

  localparam int LW = $clog2(`STROBES);

  logic [LW-1:0] lane_q;
  logic [`STROBES-1:0] strb_base;
  logic take;

  // A word may be refilled in the cycle it is accepted
  assign byte_ready_o = !wvalid_o || wready_i;
  assign take = byte_valid_i && byte_ready_o;
  assign strb_base = wvalid_o ? '0 : wstrb_o;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      lane_q <= '0;
      wstrb_o <= '0;
      wvalid_o <= 1'b0;
      wlast_o <= 1'b0;
    end else begin
      if (wvalid_o && wready_i) begin
        wvalid_o <= 1'b0;
        wstrb_o <= '0;
      end
      if (take) begin
        wstrb_o <= strb_base | (`STROBES'(1) << lane_q);
        lane_q <= lane_q + 1'b1;
        if (lane_q == LW'(`STROBES - 1) || byte_last_i) begin
          wvalid_o <= 1'b1;
          wlast_o <= byte_last_i;
          lane_q <= '0;  // Partial word keeps only its strobes
        end
      end
    end
  end

  always_ff @(posedge bus_clock) begin
    if (take) begin
      wdata_o[lane_q*8 +: 8] <= byte_i;
    end
  end

endmodule

/* hdl/rd_unpack.sv */
`timescale 1ns/100ps
`include "memreq_defs.svh"

module rd_unpack (
  input  logic bus_clock,
  input  logic bus_reset,
  input  logic rvalid_i,
  output logic rready_o,
  input  logic rlast_i,
  input  logic [1:0] rresp_i,
  input  logic [`DATA_WIDTH-1:0] rdata_i,
  output logic rd_status_valid_o,
  output logic rd_ok_o,
  output logic rd_byte_valid_o,
  output logic [7:0] rd_byte_o,
  output logic rd_byte_last_o,
  input  logic rd_byte_take_i,
  input  logic resp_done_i
);

  localparam int DEPTH = `RD_FIFO_DEPTH;
  localparam int PW = $clog2(DEPTH);
  localparam int LW = $clog2(`STROBES);

  logic [`DATA_WIDTH-1:0] data_mem [DEPTH];
  logic last_mem [DEPTH];
  logic [PW:0] wr_ptr_q, rd_ptr_q;  // Extra bit tells full from empty
  logic [LW-1:0] lane_q;
  logic full, push, pop, head_last;

  assign full = wr_ptr_q[PW] != rd_ptr_q[PW] && wr_ptr_q[PW-1:0] == rd_ptr_q[PW-1:0];
  assign rready_o = !full;
  assign push = rvalid_i && rready_o;
  assign pop = rd_byte_take_i && lane_q == LW'(`STROBES - 1);

  always_ff @(posedge bus_clock) begin
    if (push) begin
      data_mem[wr_ptr_q[PW-1:0]] <= rdata_i;
      last_mem[wr_ptr_q[PW-1:0]] <= rlast_i;
    end
  end

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      lane_q <= '0;
    end else begin
      wr_ptr_q <= push ? wr_ptr_q + 1'b1 : wr_ptr_q;
      rd_ptr_q <= pop ? rd_ptr_q + 1'b1 : rd_ptr_q;
      if (rd_byte_take_i) begin
        lane_q <= lane_q + 1'b1;
      end
    end
  end

  // Low byte of each word goes first
  assign head_last = last_mem[rd_ptr_q[PW-1:0]];
  assign rd_byte_valid_o = wr_ptr_q != rd_ptr_q;
  assign rd_byte_o = data_mem[rd_ptr_q[PW-1:0]][lane_q*8 +: 8];
  assign rd_byte_last_o = head_last && lane_q == LW'(`STROBES - 1);

  // Burst status comes from the first beat only
  always_ff @(posedge bus_clock) begin
    if (bus_reset || resp_done_i) begin
      rd_status_valid_o <= 1'b0;
      rd_ok_o <= 1'b0;
    end else if (push && !rd_status_valid_o) begin
      rd_status_valid_o <= 1'b1;
      rd_ok_o <= rresp_i == `RESP_OKAY;
    end
  end

endmodule

/* hdl/resp_mux.sv */
`timescale 1ns/100ps
`include "memreq_defs.svh"

module resp_mux (
  input  logic bus_clock,
  input  logic bus_reset,
  input  logic req_go_i,
  input  logic is_read_i,
  input  memreq_pkg::req_header_u header_i,
  input  logic bvalid_i,
  output logic bready_o,
  input  logic [1:0] bresp_i,
  input  logic [`ID_WIDTH-1:0] bid_i,
  input  logic rd_status_valid_i,
  input  logic rd_ok_i,
  input  logic rd_byte_valid_i,
  input  logic [7:0] rd_byte_i,
  input  logic rd_byte_last_i,
  output logic rd_byte_take_o,
  output logic m_tvalid_o,
  input  logic m_tready_i,
  output logic m_tlast_o,
  output logic [7:0] m_tdata_o,
  output logic resp_done_o
);

  import memreq_pkg::*;

  localparam logic [2:0] ST_IDLE = 3'd0;
  localparam logic [2:0] ST_BWAIT = 3'd1;
  localparam logic [2:0] ST_RWAIT = 3'd2;
  localparam logic [2:0] ST_STATUS = 3'd3;
  localparam logic [2:0] ST_ID = 3'd4;
  localparam logic [2:0] ST_DATA = 3'd5;

  logic [2:0] state_q;
  cmd_e status_q;
  logic [7:0] id_q;
  logic m_fire;

  assign bready_o = state_q == ST_BWAIT;
  assign m_fire = m_tvalid_o && m_tready_i;
  assign rd_byte_take_o = state_q == ST_DATA && m_tready_i && rd_byte_valid_i;

  always_comb begin
    case (state_q)
      ST_STATUS, ST_ID: m_tvalid_o = 1'b1;
      ST_DATA: m_tvalid_o = rd_byte_valid_i;
      default: m_tvalid_o = 1'b0;
    endcase
  end

  assign m_tlast_o = state_q == ST_ID && !is_read_i || state_q == ST_DATA && rd_byte_last_i;
  assign m_tdata_o = state_q == ST_STATUS ? status_q : state_q == ST_ID ? id_q : rd_byte_i;

  always_ff @(posedge bus_clock) begin
    if (bus_reset) begin
      state_q <= ST_IDLE;
      resp_done_o <= 1'b0;
    end else begin
      resp_done_o <= 1'b0;
      case (state_q)
        ST_IDLE: state_q <= req_go_i ? (is_read_i ? ST_RWAIT : ST_BWAIT) : state_q;
        ST_BWAIT: state_q <= bvalid_i ? ST_STATUS : state_q;
        ST_RWAIT: state_q <= rd_status_valid_i ? ST_STATUS : state_q;
        ST_STATUS: state_q <= m_fire ? ST_ID : state_q;
        ST_ID: begin
          if (m_fire) begin
            state_q <= is_read_i ? ST_DATA : ST_IDLE;
            resp_done_o <= !is_read_i;  // Store ends after its ID byte
          end
        end
        default: begin
          if (m_fire && rd_byte_last_i) begin
            state_q <= ST_IDLE;
            resp_done_o <= 1'b1;
          end
        end
      endcase
    end
  end

  always_ff @(posedge bus_clock) begin
    if (state_q == ST_BWAIT && bvalid_i) begin
      status_q <= bresp_i == `RESP_OKAY ? WDONE : WFAIL;
      id_q <= {{(8 - `ID_WIDTH){1'b0}}, bid_i};
    end else if (state_q == ST_RWAIT && rd_status_valid_i) begin
      status_q <= rd_ok_i ? RDATA : RFAIL;
      id_q <= {{(8 - `ID_WIDTH){1'b0}}, header_i.f.id};
    end
  end

endmodule

/* hdl/memreq_top.sv */
`timescale 1ns/100ps
`include "memreq_defs.svh"

module memreq_top (
  input  logic bus_clock,
  input  logic bus_reset,

  // From USB or SPI
  input  logic s_tvalid_i,
  output logic s_tready_o,
  input  logic s_tlast_i,
  input  logic [7:0] s_tdata_i,

  // To USB or SPI
  output logic m_tvalid_o,
  input  logic m_tready_i,
  output logic m_tlast_o,
  output logic [7:0] m_tdata_o,

  output logic awvalid_o,
  input  logic awready_i,
  output logic [`ADDR_WIDTH-1:0] awaddr_o,
  output logic [`ID_WIDTH-1:0] awid_o,
  output logic [7:0] awlen_o,
  output logic [1:0] awburst_o,

  output logic wvalid_o,
  input  logic wready_i,
  output logic wlast_o,
  output logic [`STROBES-1:0] wstrb_o,
  output logic [`DATA_WIDTH-1:0] wdata_o,

  input  logic bvalid_i,
  output logic bready_o,
  input  logic [1:0] bresp_i,
  input  logic [`ID_WIDTH-1:0] bid_i,

  output logic arvalid_o,
  input  logic arready_i,
  output logic [`ADDR_WIDTH-1:0] araddr_o,
  output logic [`ID_WIDTH-1:0] arid_o,
  output logic [7:0] arlen_o,
  output logic [1:0] arburst_o,

  input  logic rvalid_i,
  output logic rready_o,
  input  logic rlast_i,
  input  logic [1:0] rresp_i,
  input  logic [`ID_WIDTH-1:0] rid_i,
  input  logic [`DATA_WIDTH-1:0] rdata_i
);

  import memreq_pkg::*;

  req_header_u header;
  logic is_read, req_go, resp_done;
  logic byte_valid, byte_last, byte_ready;
  logic [7:0] wr_byte;
  logic rd_status_valid, rd_ok;
  logic rd_byte_valid, rd_byte_last, rd_byte_take;
  logic [7:0] rd_byte;

  cmd_parser u_parser (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .s_tvalid_i(s_tvalid_i), .s_tready_o(s_tready_o),
    .s_tlast_i(s_tlast_i), .s_tdata_i(s_tdata_i),
    .header_o(header), .is_read_o(is_read), .req_go_o(req_go),
    .byte_valid_o(byte_valid), .byte_last_o(byte_last), .byte_o(wr_byte),
    .byte_ready_i(byte_ready), .resp_done_i(resp_done)
  );

  addr_issue u_addr (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .req_go_i(req_go), .is_read_i(is_read), .header_i(header),
    .awvalid_o(awvalid_o), .awready_i(awready_i), .awaddr_o(awaddr_o),
    .awid_o(awid_o), .awlen_o(awlen_o), .awburst_o(awburst_o),
    .arvalid_o(arvalid_o), .arready_i(arready_i), .araddr_o(araddr_o),
    .arid_o(arid_o), .arlen_o(arlen_o), .arburst_o(arburst_o)
  );

  wr_packer u_pack (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .byte_valid_i(byte_valid), .byte_last_i(byte_last), .byte_i(wr_byte),
    .byte_ready_o(byte_ready),
    .wvalid_o(wvalid_o), .wready_i(wready_i), .wlast_o(wlast_o),
    .wstrb_o(wstrb_o), .wdata_o(wdata_o)
  );

  rd_unpack u_unpack (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .rvalid_i(rvalid_i), .rready_o(rready_o), .rlast_i(rlast_i),
    .rresp_i(rresp_i), .rdata_i(rdata_i),
    .rd_status_valid_o(rd_status_valid), .rd_ok_o(rd_ok),
    .rd_byte_valid_o(rd_byte_valid), .rd_byte_o(rd_byte),
    .rd_byte_last_o(rd_byte_last), .rd_byte_take_i(rd_byte_take),
    .resp_done_i(resp_done)
  );

  resp_mux u_resp (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .req_go_i(req_go), .is_read_i(is_read), .header_i(header),
    .bvalid_i(bvalid_i), .bready_o(bready_o), .bresp_i(bresp_i), .bid_i(bid_i),
    .rd_status_valid_i(rd_status_valid), .rd_ok_i(rd_ok),
    .rd_byte_valid_i(rd_byte_valid), .rd_byte_i(rd_byte),
    .rd_byte_last_i(rd_byte_last), .rd_byte_take_o(rd_byte_take),
    .m_tvalid_o(m_tvalid_o), .m_tready_i(m_tready_i),
    .m_tlast_o(m_tlast_o), .m_tdata_o(m_tdata_o),
    .resp_done_o(resp_done)
  );

endmodule

/* tests/axi_mem_model.sv */
`timescale 1ns/100ps
`include "memreq_defs.svh"

module axi_mem_model (
  input  logic bus_clock,
  input  logic awvalid_i,
  output logic awready_o,
  input  logic [`ADDR_WIDTH-1:0] awaddr_i,
  input  logic [`ID_WIDTH-1:0] awid_i,
  input  logic [7:0] awlen_i,
  input  logic wvalid_i,
  output logic wready_o,
  input  logic [`STROBES-1:0] wstrb_i,
  input  logic [`DATA_WIDTH-1:0] wdata_i,
  output logic bvalid_o,
  input  logic bready_i,
  output logic [1:0] bresp_o,
  output logic [`ID_WIDTH-1:0] bid_o,
  input  logic arvalid_i,
  output logic arready_o,
  input  logic [`ADDR_WIDTH-1:0] araddr_i,
  input  logic [`ID_WIDTH-1:0] arid_i,
  input  logic [7:0] arlen_i,
  output logic rvalid_o,
  input  logic rready_i,
  output logic rlast_o,
  output logic [1:0] rresp_o,
  output logic [`ID_WIDTH-1:0] rid_o,
  output logic [`DATA_WIDTH-1:0] rdata_o
);

  localparam logic [1:0] RESP_SLVERR = 2'b10;

  logic [`DATA_WIDTH-1:0] mem [1024];  // Indexed by addr[11:2]
  integer seed = 32'h78c0c494;

  task automatic ready_delay();
    int d;
    d = $unsigned($random(seed)) % 4;
    repeat (d) @(negedge bus_clock);
  endtask

  initial begin : fill
    int i;
    for (i = 0; i < 1024; i++) begin
      mem[i] = 32'h9e3779b9 * (i + 1);
    end
  end

  initial begin : write_side
    logic [`ADDR_WIDTH-1:0] addr;
    logic [`ID_WIDTH-1:0] id;
    logic [7:0] len;
    logic [9:0] idx;
    int beat;
    int b;
    awready_o = 1'b0;
    wready_o = 1'b0;
    bvalid_o = 1'b0;
    bresp_o = `RESP_OKAY;
    bid_o = '0;
    forever begin
      @(negedge bus_clock);
      if (awvalid_i) begin
        ready_delay();
        awready_o = 1'b1;
        @(posedge bus_clock);
        addr = awaddr_i;
        id = awid_i;
        len = awlen_i;
        @(negedge bus_clock);
        awready_o = 1'b0;
        for (beat = 0; beat <= int'(len); beat++) begin
          ready_delay();
          wready_o = 1'b1;
          do @(posedge bus_clock); while (!wvalid_i);
          idx = addr[11:2] + 10'(beat);
          for (b = 0; b < `STROBES; b++) begin
            if (wstrb_i[b] && !addr[27]) begin
              mem[idx][b*8 +: 8] = wdata_i[b*8 +: 8];
            end
          end
          @(negedge bus_clock);
          wready_o = 1'b0;
        end
        ready_delay();
        bvalid_o = 1'b1;
        bid_o = id;
        bresp_o = addr[27] ? RESP_SLVERR : `RESP_OKAY;  // Bit 27 marks a bad region
        do @(posedge bus_clock); while (!bready_i);
        @(negedge bus_clock);
        bvalid_o = 1'b0;
      end
    end
  end

  initial begin : read_side
    logic [`ADDR_WIDTH-1:0] addr;
    logic [7:0] len;
    int beat;
    arready_o = 1'b0;
    rvalid_o = 1'b0;
    rlast_o = 1'b0;
    rresp_o = `RESP_OKAY;
    rid_o = '0;
    rdata_o = '0;
    forever begin
      @(negedge bus_clock);
      if (arvalid_i) begin
        ready_delay();
        arready_o = 1'b1;
        @(posedge bus_clock);
        addr = araddr_i;
        len = arlen_i;
        rid_o = arid_i;
        @(negedge bus_clock);
        arready_o = 1'b0;
        for (beat = 0; beat <= int'(len); beat++) begin
          ready_delay();
          rvalid_o = 1'b1;
          rdata_o = mem[addr[11:2] + 10'(beat)];
          rlast_o = beat == int'(len);
          rresp_o = addr[27] ? RESP_SLVERR : `RESP_OKAY;
          do @(posedge bus_clock); while (!rready_i);
          @(negedge bus_clock);
          rvalid_o = 1'b0;
          rlast_o = 1'b0;
        end
      end
    end
  end

endmodule

/* tests/memreq_assertions.sv */
`timescale 1ns/100ps
`include "memreq_defs.svh"

module memreq_assertions (
  input logic bus_clock,
  input logic bus_reset,
  input logic awvalid_i,
  input logic awready_i,
  input logic [`ADDR_WIDTH-1:0] awaddr_i,
  input logic [7:0] awlen_i,
  input logic arvalid_i,
  input logic arready_i,
  input logic [`ADDR_WIDTH-1:0] araddr_i,
  input logic [7:0] arlen_i,
  input logic m_tvalid_i,
  input logic m_tready_i,
  input logic m_tlast_i,
  input logic [7:0] m_tdata_i
);

  int fail_count = 0;

  aw_hold: assert property (@(posedge bus_clock) disable iff (bus_reset)
    awvalid_i && !awready_i |=> awvalid_i && $stable(awaddr_i) && $stable(awlen_i))
    else begin
      fail_count++;
      $error("AW request dropped or changed before awready");
    end

  ar_hold: assert property (@(posedge bus_clock) disable iff (bus_reset)
    arvalid_i && !arready_i |=> arvalid_i && $stable(araddr_i) && $stable(arlen_i))
    else begin
      fail_count++;
      $error("AR request dropped or changed before arready");
    end

  // Output byte must not move while the host stalls
  m_hold: assert property (@(posedge bus_clock) disable iff (bus_reset)
    m_tvalid_i && !m_tready_i |=> m_tvalid_i && $stable(m_tdata_i) && $stable(m_tlast_i))
    else begin
      fail_count++;
      $error("Output byte dropped or changed before m_tready");
    end

  one_addr: assert property (@(posedge bus_clock) disable iff (bus_reset)
    !(awvalid_i && arvalid_i))
    else begin
      fail_count++;
      $error("AW and AR requests raised together");
    end

endmodule

bind memreq_top memreq_assertions u_assertions (
  .bus_clock(bus_clock), .bus_reset(bus_reset),
  .awvalid_i(awvalid_o), .awready_i(awready_i), .awaddr_i(awaddr_o), .awlen_i(awlen_o),
  .arvalid_i(arvalid_o), .arready_i(arready_i), .araddr_i(araddr_o), .arlen_i(arlen_o),
  .m_tvalid_i(m_tvalid_o), .m_tready_i(m_tready_i), .m_tlast_i(m_tlast_o),
  .m_tdata_i(m_tdata_o)
);

/* tests/tb_memreq.sv */
`timescale 1ns/100ps
`include "memreq_defs.svh"

module tb_memreq;

  import memreq_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_TESTS = 5;
  localparam int TEST_CYCLES = 3000;
  localparam logic [1:0] AXI_INCR = 2'b01;

  logic bus_clock = 1'b0;
  logic bus_reset;
  logic s_tvalid, s_tready, s_tlast;
  logic [7:0] s_tdata;
  logic m_tvalid, m_tready, m_tlast;
  logic [7:0] m_tdata;
  logic awvalid, awready, wvalid, wready, wlast, bvalid, bready;
  logic arvalid, arready, rvalid, rready, rlast;
  logic [`ADDR_WIDTH-1:0] awaddr, araddr;
  logic [`ID_WIDTH-1:0] awid, arid, bid, rid;
  logic [7:0] awlen, arlen;
  logic [1:0] awburst, arburst, bresp, rresp;
  logic [`STROBES-1:0] wstrb;
  logic [`DATA_WIDTH-1:0] wdata, rdata;

  integer seed;
  int errors;
  int checks;
  int tests;
  logic [`STROBES-1:0] last_wstrb;
  int w_beats = 0;
  int wlast_beats = 0;
  int wlast_at;  // Running W beat number of the latest wlast
  logic [1:0] aw_burst_seen, ar_burst_seen;
  logic [`ID_WIDTH-1:0] ar_id_seen;
  logic [7:0] tx_q[$];
  logic [7:0] rx_q[$];
  logic [`DATA_WIDTH-1:0] shadow [1024];  // Expected memory contents

  memreq_top UUT (
    .bus_clock(bus_clock), .bus_reset(bus_reset),
    .s_tvalid_i(s_tvalid), .s_tready_o(s_tready), .s_tlast_i(s_tlast), .s_tdata_i(s_tdata),
    .m_tvalid_o(m_tvalid), .m_tready_i(m_tready), .m_tlast_o(m_tlast), .m_tdata_o(m_tdata),
    .awvalid_o(awvalid), .awready_i(awready), .awaddr_o(awaddr), .awid_o(awid),
    .awlen_o(awlen), .awburst_o(awburst),
    .wvalid_o(wvalid), .wready_i(wready), .wlast_o(wlast), .wstrb_o(wstrb), .wdata_o(wdata),
    .bvalid_i(bvalid), .bready_o(bready), .bresp_i(bresp), .bid_i(bid),
    .arvalid_o(arvalid), .arready_i(arready), .araddr_o(araddr), .arid_o(arid),
    .arlen_o(arlen), .arburst_o(arburst),
    .rvalid_i(rvalid), .rready_o(rready), .rlast_i(rlast), .rresp_i(rresp),
    .rid_i(rid), .rdata_i(rdata)
  );

  axi_mem_model u_mem (
    .bus_clock(bus_clock),
    .awvalid_i(awvalid), .awready_o(awready), .awaddr_i(awaddr), .awid_i(awid),
    .awlen_i(awlen), .wvalid_i(wvalid), .wready_o(wready), .wstrb_i(wstrb), .wdata_i(wdata),
    .bvalid_o(bvalid), .bready_i(bready), .bresp_o(bresp), .bid_o(bid),
    .arvalid_i(arvalid), .arready_o(arready), .araddr_i(araddr), .arid_i(arid),
    .arlen_i(arlen), .rvalid_o(rvalid), .rready_i(rready), .rlast_o(rlast),
    .rresp_o(rresp), .rid_o(rid), .rdata_o(rdata)
  );

  always #(CLK_PERIOD / 2) bus_clock = ~bus_clock;

  // W beats, wlast position and the accepted request fields
  always @(posedge bus_clock) begin
    if (wvalid && wready) begin
      w_beats <= w_beats + 1;
      if (wlast) begin
        wlast_beats <= wlast_beats + 1;
        wlast_at <= w_beats + 1;
        last_wstrb <= wstrb;  // Strobes of the final word
      end
    end
    if (awvalid && awready) begin
      aw_burst_seen <= awburst;
    end
    if (arvalid && arready) begin
      ar_burst_seen <= arburst;
      ar_id_seen <= arid;
    end
  end

  task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                       input string msg);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAIL %0t ns: %s, got %0h, expected %0h", $time, msg, actual, expected);
    end
  endtask

  task automatic send_frame();
    int i;
    for (i = 0; i < tx_q.size(); i++) begin
      @(negedge bus_clock);
      s_tvalid = 1'b1;
      s_tdata = tx_q[i];
      s_tlast = i == tx_q.size() - 1;
      do @(posedge bus_clock); while (!s_tready);
    end
    @(negedge bus_clock);
    s_tvalid = 1'b0;
    s_tlast = 1'b0;
  endtask

  task automatic collect_resp(input bit gappy);
    bit done;
    done = 1'b0;
    rx_q.delete();
    while (!done) begin
      @(negedge bus_clock);
      m_tready = gappy ? $unsigned($random(seed)) % 3 != 0 : 1'b1;
      @(posedge bus_clock);
      if (m_tvalid && m_tready) begin
        rx_q.push_back(m_tdata);
        done = m_tlast;
      end
    end
    @(negedge bus_clock);
    m_tready = 1'b0;
  endtask

  task automatic run_frame(input bit gappy);
    fork
      send_frame();
      collect_resp(gappy);
    join
  endtask

  // Command byte, then len, address low to high, and {id, addr[27:24]}
  task automatic build_header(input logic [7:0] cmd, input logic [3:0] id,
                              input logic [27:0] addr, input int beats);
    tx_q.delete();
    tx_q.push_back(cmd);
    tx_q.push_back(8'(beats - 1));
    tx_q.push_back(addr[7:0]);
    tx_q.push_back(addr[15:8]);
    tx_q.push_back(addr[23:16]);
    tx_q.push_back({id, addr[27:24]});
  endtask

  task automatic store(input logic [3:0] id, input logic [27:0] addr, input int nbytes);
    int i;
    int w_before;
    int wlast_before;
    logic [7:0] d;
    logic [9:0] idx;
    logic [7:0] status;
    build_header(STORE, id, addr, (nbytes + 3) / 4);
    for (i = 0; i < nbytes; i++) begin
      d = 8'($random(seed));
      tx_q.push_back(d);
      idx = addr[11:2] + 10'(i / 4);
      if (!addr[27]) begin
        shadow[idx][(i % 4) * 8 +: 8] = d;  // Failed stores leave memory alone
      end
    end
    w_before = w_beats;
    wlast_before = wlast_beats;
    run_frame(1'b0);
    status = addr[27] ? WFAIL : WDONE;
    check(w_beats - w_before, (nbytes + 3) / 4, "W beat count");
    check(wlast_beats - wlast_before, 1, "wlast count");
    check(wlast_at - w_before, (nbytes + 3) / 4, "wlast position");
    check(aw_burst_seen, AXI_INCR, "awburst");
    check(rx_q.size(), 2, "store response length");
    if (rx_q.size() == 2) begin
      check(rx_q[0], status, "store status");
      check(rx_q[1], id, "store id");
    end
  endtask

  task automatic fetch(input logic [3:0] id, input logic [27:0] addr, input int beats,
                       input bit gappy);
    int i;
    logic [9:0] idx;
    logic [7:0] status;
    build_header(FETCH, id, addr, beats);
    run_frame(gappy);
    status = addr[27] ? RFAIL : RDATA;
    check(ar_id_seen, id, "arid");
    check(ar_burst_seen, AXI_INCR, "arburst");
    check(rx_q.size(), 2 + 4 * beats, "fetch response length");
    if (rx_q.size() == 2 + 4 * beats) begin
      check(rx_q[0], status, "fetch status");
      check(rx_q[1], id, "fetch id");
      for (i = 0; i < 4 * beats; i++) begin
        idx = addr[11:2] + 10'(i / 4);
        check(rx_q[2 + i], shadow[idx][(i % 4) * 8 +: 8], "fetch data");
      end
    end
  endtask

  task automatic end_test(input string name, input int errors_before);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
  endtask

  task automatic test_store_fetch();
    int e;
    e = errors;
    check(s_tready, 1, "s_tready after reset");
    check({awvalid, arvalid, wvalid, bready, m_tvalid}, 0, "valids after reset");
    store(4'h3, 28'h0000100, 16);
    fetch(4'h3, 28'h0000100, 4, 1'b0);
    end_test("store then fetch of 4 beats", e);
  endtask

  task automatic test_partial_store();
    int e;
    e = errors;
    store(4'h5, 28'h0000200, 10);
    check(last_wstrb, 4'b0011, "strobes of the partial word");
    fetch(4'h6, 28'h0000200, 3, 1'b0);
    end_test("store of 10 bytes", e);
  endtask

  task automatic test_store_error();
    int e;
    e = errors;
    store(4'h9, 28'h8000300, 8);
    end_test("store with slave error", e);
  endtask

  task automatic test_fetch_error();
    int e;
    e = errors;
    fetch(4'ha, 28'h8000300, 2, 1'b0);
    end_test("fetch with slave error", e);
  endtask

  task automatic test_long_fetch();
    int e;
    e = errors;
    fetch(4'hc, 28'h0000400, 16, 1'b1);  // Output stalls fill the read FIFO
    end_test("fetch of 16 beats with stalls", e);
  endtask

  initial begin : watchdog
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Timeout: the tests did not finish within %0d cycles", NUM_TESTS * TEST_CYCLES);
    $display("sim failed");
    $finish;
  end

  initial begin : main
    int i;
    seed = 32'h78c0c494;
    errors = 0;
    checks = 0;
    tests = 0;
    bus_reset = 1'b1;
    s_tvalid = 1'b0;
    s_tlast = 1'b0;
    s_tdata = 8'h00;
    m_tready = 1'b0;
    for (i = 0; i < 1024; i++) begin
      shadow[i] = 32'h9e3779b9 * (i + 1);
    end
    repeat (3) @(posedge bus_clock);
    @(negedge bus_clock);
    bus_reset = 1'b0;
    @(posedge bus_clock);
    test_store_fetch();
    test_partial_store();
    test_store_error();
    test_fetch_error();
    test_long_fetch();
    errors = errors + UUT.u_assertions.fail_count;
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
+incdir+hdl
hdl/memreq_pkg.sv
hdl/cmd_parser.sv
hdl/addr_issue.sv
hdl/wr_packer.sv
hdl/rd_unpack.sv
hdl/resp_mux.sv
hdl/memreq_top.sv
tests/axi_mem_model.sv
tests/memreq_assertions.sv
tests/tb_memreq.sv

/* Makefile */
SIM      := verilator
TOP      := tb_memreq
FILELIST := filelist.f
FLAGS    := --binary --timing --assert -Wno-fatal
OBJ_DIR  := obj_dir

SOURCES  := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv)
BIN      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "sim passed"

clean:
	rm -rf $(OBJ_DIR)
